// File: design/udp_rx_pkg.sv
package udp_rx_pkg;

    // basic field widths
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] word_t;
    typedef logic [31:0] ip_addr_t;

    // one byte of a frame with its framing marks
    typedef struct packed {
        byte_t data;
        logic  sof;
        logic  eof;
    } stream_beat_t;

    // udp header in wire order, source port first
    typedef struct packed {
        word_t src_port;
        word_t dst_port;
        word_t length;
        word_t checksum;
    } udp_fields_t;

    // fixed header sizes in bytes
    localparam int ETH_HEADER_BYTES = 14;
    localparam int IP_HEADER_BYTES  = 20;
    localparam int UDP_HEADER_BYTES = 8;

    // acceptance values
    localparam word_t      ETHERTYPE_IPV4 = 16'h0800;
    localparam logic [3:0] IP_VERSION_4   = 4'h4;
    localparam byte_t      IP_PROTO_UDP   = 8'h11;

    // parser FSM states
    // release_out stands for the release phase, release being a keyword
    typedef enum logic [2:0] {
        idle_skip,
        eth_header,
        ip_header,
        udp_header,
        payload,
        fold_wait,
        release_out,
        clear
    } parser_state_t;

endpackage

// File: design/payload_fifo.sv
`timescale 1ns/100ps

module payload_fifo #(
    parameter int FIFO_ADDR_BITS = 8
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     clear,
    input  logic                     wr_en,
    input  udp_rx_pkg::stream_beat_t wr_beat,
    output logic                     full,
    input  logic                     rd_en,
    output udp_rx_pkg::stream_beat_t rd_beat,
    output logic                     empty
);

    localparam int DEPTH = 1 << FIFO_ADDR_BITS;

    udp_rx_pkg::stream_beat_t  mem [DEPTH];
    logic [FIFO_ADDR_BITS:0]   wr_ptr;
    logic [FIFO_ADDR_BITS:0]   rd_ptr;
    logic                      do_write;
    logic                      do_read;

    // extra pointer bit tells a full buffer from an empty one
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[FIFO_ADDR_BITS] != rd_ptr[FIFO_ADDR_BITS]) &&
                   (wr_ptr[FIFO_ADDR_BITS-1:0] == rd_ptr[FIFO_ADDR_BITS-1:0]);

    assign do_write = wr_en && !full;
    assign do_read  = rd_en && !empty;

    // show-ahead, head is visible before the pop
    assign rd_beat = mem[rd_ptr[FIFO_ADDR_BITS-1:0]];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (do_write) begin
            mem[wr_ptr[FIFO_ADDR_BITS-1:0]] <= wr_beat;
        end
    end

endmodule

// File: design/udp_checksum.sv
`timescale 1ns/100ps

module udp_checksum (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    sum_clear,
    input  logic                    sum_byte_valid,
    input  udp_rx_pkg::byte_t       sum_byte,
    input  logic                    sum_finish,
    input  udp_rx_pkg::udp_fields_t udp_fields,
    output logic                    verdict_valid,
    output logic                    checksum_ok
);

    logic [31:0]       sum;
    udp_rx_pkg::byte_t high_byte;
    udp_rx_pkg::word_t pad_word;
    logic              half;
    logic              folding;

    // a lone trailing byte is the high half of a zero-padded word
    assign pad_word = half ? {high_byte, 8'h00} : '0;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            half          <= 1'b0;
            folding       <= 1'b0;
            verdict_valid <= 1'b0;
            checksum_ok   <= 1'b0;
        end else begin
            verdict_valid <= 1'b0;
            if (sum_clear) begin
                half    <= 1'b0;
                folding <= 1'b0;
            end else if (sum_finish) begin
                half    <= 1'b0;
                folding <= 1'b1;
            end else if (sum_byte_valid) begin
                half <= !half;
            end else if (folding && sum[31:16] == '0) begin
                folding       <= 1'b0;
                verdict_valid <= 1'b1;
                checksum_ok   <= (~sum[15:0] == udp_fields.checksum);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (sum_clear) begin
            // protocol term of the pseudo-header
            sum <= 32'(udp_rx_pkg::IP_PROTO_UDP);
        end else if (sum_finish) begin
            sum <= sum + 32'(udp_fields.length) + 32'(pad_word);
        end else if (sum_byte_valid && half) begin
            sum <= sum + {16'h0000, high_byte, sum_byte};
        end else if (folding && sum[31:16] != '0) begin
            sum <= {16'h0000, sum[31:16]} + {16'h0000, sum[15:0]};
        end
        if (sum_byte_valid && !half) begin
            high_byte <= sum_byte;
        end
    end

endmodule

// File: design/frame_parser.sv
`timescale 1ns/100ps

module frame_parser (
    input  logic                     clock,
    input  logic                     reset,
    input  udp_rx_pkg::stream_beat_t in_beat,
    input  logic                     in_empty,
    output logic                     in_rd_en,
    output udp_rx_pkg::stream_beat_t out_beat,
    output logic                     out_wr_en,
    input  logic                     out_full,
    output logic                     sum_clear,
    output logic                     sum_byte_valid,
    output udp_rx_pkg::byte_t        sum_byte,
    output logic                     sum_finish,
    output udp_rx_pkg::udp_fields_t  udp_fields,
    input  logic                     verdict_valid,
    input  logic                     checksum_ok,
    output logic                     fifo_wr_en,
    output udp_rx_pkg::stream_beat_t fifo_wr_beat,
    input  logic                     fifo_full,
    output logic                     fifo_clear,
    output logic                     fifo_rd_en,
    input  udp_rx_pkg::stream_beat_t fifo_rd_beat,
    input  logic                     fifo_empty
);

    // byte offsets inside each header
    localparam logic [4:0] ETH_TYPE_HI = 5'(udp_rx_pkg::ETH_HEADER_BYTES - 2);
    localparam logic [4:0] ETH_LAST    = 5'(udp_rx_pkg::ETH_HEADER_BYTES - 1);
    localparam logic [4:0] IP_TTL      = 5'd8;
    localparam logic [4:0] IP_PROTO    = 5'd9;
    localparam logic [4:0] IP_SRC      = 5'd12;
    localparam logic [4:0] IP_LAST     = 5'(udp_rx_pkg::IP_HEADER_BYTES - 1);
    localparam logic [4:0] UDP_CSUM    = 5'd6;
    localparam logic [4:0] UDP_LAST    = 5'(udp_rx_pkg::UDP_HEADER_BYTES - 1);

    udp_rx_pkg::parser_state_t state;
    udp_rx_pkg::parser_state_t state_next;
    udp_rx_pkg::parser_state_t hdr_next;
    logic [4:0]                byte_cnt;
    udp_rx_pkg::word_t         pay_cnt;
    udp_rx_pkg::byte_t         ether_hi;
    logic                      hdr_active;
    logic                      hdr_fail;
    logic                      hdr_done;
    logic                      pay_last;

    // payload stops at eof or at the udp length, whichever is first
    assign pay_last = in_beat.eof ||
        (pay_cnt == udp_fields.length - 16'(udp_rx_pkg::UDP_HEADER_BYTES + 1));

    assign fifo_wr_beat = '{data: in_beat.data, sof: (pay_cnt == '0), eof: pay_last};
    assign out_beat = fifo_rd_beat;

    always_comb begin
        state_next     = state;
        hdr_next       = state;
        hdr_active     = 1'b0;
        hdr_fail       = 1'b0;
        hdr_done       = 1'b0;
        in_rd_en       = 1'b0;
        sum_clear      = 1'b0;
        sum_byte_valid = 1'b0;
        sum_byte       = in_beat.data;
        fifo_wr_en     = 1'b0;
        fifo_clear     = 1'b0;
        fifo_rd_en     = 1'b0;
        out_wr_en      = 1'b0;
        case (state)
            udp_rx_pkg::idle_skip: begin
                in_rd_en = !in_empty;
                if (!in_empty && in_beat.sof) begin
                    sum_clear  = 1'b1;
                    state_next = udp_rx_pkg::eth_header;
                end
            end
            udp_rx_pkg::eth_header: begin
                hdr_active = 1'b1;
                hdr_done   = (byte_cnt == ETH_LAST);
                hdr_fail   = hdr_done &&
                    ({ether_hi, in_beat.data} != udp_rx_pkg::ETHERTYPE_IPV4);
                hdr_next   = udp_rx_pkg::ip_header;
            end
            udp_rx_pkg::ip_header: begin
                hdr_active     = 1'b1;
                hdr_done       = (byte_cnt == IP_LAST);
                hdr_fail       = (byte_cnt == '0 &&
                                  in_beat.data[7:4] != udp_rx_pkg::IP_VERSION_4) ||
                                 (byte_cnt == IP_TTL && in_beat.data == '0) ||
                                 (byte_cnt == IP_PROTO &&
                                  in_beat.data != udp_rx_pkg::IP_PROTO_UDP);
                // source and destination addresses go into the pseudo-header
                sum_byte_valid = !in_empty && byte_cnt >= IP_SRC;
                hdr_next       = udp_rx_pkg::udp_header;
            end
            udp_rx_pkg::udp_header: begin
                hdr_active     = 1'b1;
                hdr_done       = (byte_cnt == UDP_LAST);
                // last byte not shifted in yet, so the length sits at [23:8]
                hdr_fail       = hdr_done &&
                    udp_fields[23:8] <= 16'(udp_rx_pkg::UDP_HEADER_BYTES);
                sum_byte_valid = !in_empty;
                // checksum field counts as zero
                sum_byte       = (byte_cnt >= UDP_CSUM) ? '0 : in_beat.data;
                hdr_next       = udp_rx_pkg::payload;
            end
            udp_rx_pkg::payload: begin
                in_rd_en       = !in_empty && !fifo_full;
                fifo_wr_en     = in_rd_en;
                sum_byte_valid = in_rd_en;
                if (in_rd_en && pay_last) begin
                    state_next = udp_rx_pkg::fold_wait;
                end
            end
            udp_rx_pkg::fold_wait: begin
                if (verdict_valid) begin
                    state_next = checksum_ok ? udp_rx_pkg::release_out : udp_rx_pkg::clear;
                end
            end
            udp_rx_pkg::release_out: begin
                out_wr_en  = !fifo_empty && !out_full;
                fifo_rd_en = out_wr_en;
                if (out_wr_en && fifo_rd_beat.eof) begin
                    state_next = udp_rx_pkg::clear;
                end
            end
            default: begin
                fifo_clear = 1'b1;
                state_next = udp_rx_pkg::idle_skip;
            end
        endcase

        // shared walk through the three headers; early eof is a truncated frame
        if (hdr_active) begin
            in_rd_en = !in_empty;
            if (!in_empty && (hdr_fail || in_beat.eof)) begin
                state_next = udp_rx_pkg::clear;
            end else if (!in_empty && hdr_done) begin
                state_next = hdr_next;
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state      <= udp_rx_pkg::idle_skip;
            byte_cnt   <= '0;
            pay_cnt    <= '0;
            sum_finish <= 1'b0;
        end else begin
            state      <= state_next;
            sum_finish <= (state == udp_rx_pkg::payload) && in_rd_en && pay_last;
            // the sof byte is header byte 0, so counting resumes at 1
            if (state == udp_rx_pkg::idle_skip) begin
                byte_cnt <= 5'd1;
            end else if (hdr_active && !in_empty) begin
                byte_cnt <= hdr_done ? '0 : byte_cnt + 5'd1;
            end
            if (state == udp_rx_pkg::udp_header) begin
                pay_cnt <= '0;
            end else if (fifo_wr_en) begin
                pay_cnt <= pay_cnt + 16'd1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (state == udp_rx_pkg::eth_header && !in_empty && byte_cnt == ETH_TYPE_HI) begin
            ether_hi <= in_beat.data;
        end
        if (state == udp_rx_pkg::udp_header && !in_empty) begin
            udp_fields <= {udp_fields[55:0], in_beat.data};
        end
    end

endmodule

// File: design/udp_rx_top.sv
`timescale 1ns/100ps

module udp_rx_top #(
    parameter int FIFO_ADDR_BITS = 8
) (
    input  logic                     clock,
    input  logic                     reset,
    input  udp_rx_pkg::stream_beat_t in_beat,
    input  logic                     in_empty,
    output logic                     in_rd_en,
    output udp_rx_pkg::stream_beat_t out_beat,
    output logic                     out_wr_en,
    input  logic                     out_full
);

    // parser to checksum unit
    logic                     sum_clear;
    logic                     sum_byte_valid;
    udp_rx_pkg::byte_t        sum_byte;
    logic                     sum_finish;
    udp_rx_pkg::udp_fields_t  udp_fields;
    logic                     verdict_valid;
    logic                     checksum_ok;

    // parser to payload buffer
    logic                     fifo_wr_en;
    udp_rx_pkg::stream_beat_t fifo_wr_beat;
    logic                     fifo_full;
    logic                     fifo_clear;
    logic                     fifo_rd_en;
    udp_rx_pkg::stream_beat_t fifo_rd_beat;
    logic                     fifo_empty;

    frame_parser u_frame_parser (
        .clock          (clock),
        .reset          (reset),
        .in_beat        (in_beat),
        .in_empty       (in_empty),
        .in_rd_en       (in_rd_en),
        .out_beat       (out_beat),
        .out_wr_en      (out_wr_en),
        .out_full       (out_full),
        .sum_clear      (sum_clear),
        .sum_byte_valid (sum_byte_valid),
        .sum_byte       (sum_byte),
        .sum_finish     (sum_finish),
        .udp_fields     (udp_fields),
        .verdict_valid  (verdict_valid),
        .checksum_ok    (checksum_ok),
        .fifo_wr_en     (fifo_wr_en),
        .fifo_wr_beat   (fifo_wr_beat),
        .fifo_full      (fifo_full),
        .fifo_clear     (fifo_clear),
        .fifo_rd_en     (fifo_rd_en),
        .fifo_rd_beat   (fifo_rd_beat),
        .fifo_empty     (fifo_empty)
    );

    udp_checksum u_udp_checksum (
        .clock          (clock),
        .reset          (reset),
        .sum_clear      (sum_clear),
        .sum_byte_valid (sum_byte_valid),
        .sum_byte       (sum_byte),
        .sum_finish     (sum_finish),
        .udp_fields     (udp_fields),
        .verdict_valid  (verdict_valid),
        .checksum_ok    (checksum_ok)
    );

    payload_fifo #(
        .FIFO_ADDR_BITS (FIFO_ADDR_BITS)
    ) u_payload_fifo (
        .clock   (clock),
        .reset   (reset),
        .clear   (fifo_clear),
        .wr_en   (fifo_wr_en),
        .wr_beat (fifo_wr_beat),
        .full    (fifo_full),
        .rd_en   (fifo_rd_en),
        .rd_beat (fifo_rd_beat),
        .empty   (fifo_empty)
    );

endmodule

// File: test/udp_rx_cases.svh
// fault placed into a frame
typedef enum logic [2:0] {
    no_fault,
    bad_ethertype,
    bad_version,
    zero_ttl,
    bad_proto,
    bad_checksum
} fault_t;

// payload length, fault, back-pressure, junk before sof, bytes past the udp length,
// and whether the payload should come out
typedef struct packed {
    udp_rx_pkg::word_t pay_len;
    fault_t            fault;
    logic              backpressure;
    logic [3:0]        junk_lead;
    logic [3:0]        junk_trail;
    logic              expect_out;
} frame_desc_t;

localparam int NUM_CASES = 15;

localparam frame_desc_t CASES [NUM_CASES] = '{
    '{16'd16, no_fault,      1'b0, 4'd0, 4'd0, 1'b1},
    '{16'd17, no_fault,      1'b0, 4'd0, 4'd0, 1'b1},
    '{16'd1,  no_fault,      1'b0, 4'd0, 4'd0, 1'b1},
    '{16'd20, bad_ethertype, 1'b0, 4'd0, 4'd0, 1'b0},
    '{16'd12, no_fault,      1'b0, 4'd0, 4'd0, 1'b1},
    '{16'd10, bad_version,   1'b0, 4'd0, 4'd0, 1'b0},
    '{16'd10, zero_ttl,      1'b0, 4'd2, 4'd0, 1'b0},
    '{16'd10, bad_proto,     1'b0, 4'd0, 4'd0, 1'b0},
    '{16'd11, bad_checksum,  1'b0, 4'd0, 4'd0, 1'b0},
    '{16'd8,  no_fault,      1'b0, 4'd0, 4'd0, 1'b1},
    '{16'd33, no_fault,      1'b1, 4'd0, 4'd0, 1'b1},
    '{16'd64, no_fault,      1'b1, 4'd0, 4'd0, 1'b1},
    '{16'd25, no_fault,      1'b0, 4'd5, 4'd3, 1'b1},
    '{16'd9,  bad_checksum,  1'b1, 4'd3, 4'd2, 1'b0},
    '{16'd40, no_fault,      1'b1, 4'd2, 4'd4, 1'b1}
};

// every byte offered upstream, junk included
function automatic int total_bytes();
    int total;
    int i;
    total = 0;
    for (i = 0; i < NUM_CASES; i++) begin
        total += udp_rx_pkg::ETH_HEADER_BYTES + udp_rx_pkg::IP_HEADER_BYTES +
                 udp_rx_pkg::UDP_HEADER_BYTES + int'(CASES[i].pay_len) +
                 int'(CASES[i].junk_lead) + int'(CASES[i].junk_trail);
    end
    return total;
endfunction

// ones' complement of the ones' complement sum, odd length padded with zero
function automatic udp_rx_pkg::word_t internet_checksum(input udp_rx_pkg::byte_t data[$]);
    logic [31:0] acc;
    int          i;
    acc = '0;
    for (i = 0; i < data.size(); i += 2) begin
        acc = acc + 32'({data[i], (i + 1 < data.size()) ? data[i + 1] : 8'h00});
    end
    while (acc[31:16] != '0) begin
        acc = {16'h0000, acc[31:16]} + {16'h0000, acc[15:0]};
    end
    return ~acc[15:0];
endfunction

function automatic void push_word(input udp_rx_pkg::word_t w);
    frame_bytes.push_back(w[15:8]);
    frame_bytes.push_back(w[7:0]);
endfunction

// lays out one frame in frame_bytes and its expected payload beats in expect_q
function automatic void build_frame(input frame_desc_t d);
    udp_rx_pkg::byte_t        covered[$];
    udp_rx_pkg::stream_beat_t beat;
    udp_rx_pkg::word_t        udp_len;
    udp_rx_pkg::word_t        csum;
    int                       ip_src;
    int                       udp_start;
    int                       pay_start;
    int                       i;
    ip_src    = udp_rx_pkg::ETH_HEADER_BYTES + 12;
    udp_start = udp_rx_pkg::ETH_HEADER_BYTES + udp_rx_pkg::IP_HEADER_BYTES;
    pay_start = udp_start + udp_rx_pkg::UDP_HEADER_BYTES;
    udp_len   = d.pay_len + 16'(udp_rx_pkg::UDP_HEADER_BYTES);
    frame_bytes.delete();
    expect_q.delete();
    // mac addresses
    for (i = 0; i < 12; i++) begin
        frame_bytes.push_back(8'(8'h10 + i));
    end
    push_word(d.fault == bad_ethertype ? 16'h86dd : udp_rx_pkg::ETHERTYPE_IPV4);
    frame_bytes.push_back(d.fault == bad_version ? 8'h65 : 8'h45);
    frame_bytes.push_back(8'h00);
    push_word(udp_len + 16'(udp_rx_pkg::IP_HEADER_BYTES));
    push_word(16'h1c46);
    push_word(16'h4000);
    frame_bytes.push_back(d.fault == zero_ttl ? 8'h00 : 8'h40);
    frame_bytes.push_back(d.fault == bad_proto ? 8'h06 : udp_rx_pkg::IP_PROTO_UDP);
    push_word(16'h0000);
    // 192.168.0.1 to 192.168.0.200
    push_word(16'hc0a8);
    push_word(16'h0001);
    push_word(16'hc0a8);
    push_word(16'h00c8);
    push_word(16'h3039);
    push_word(16'h1234);
    push_word(udp_len);
    push_word(16'h0000);
    for (i = 0; i < int'(d.pay_len); i++) begin
        frame_bytes.push_back(8'(take_bits(data_lfsr, 8)));
    end
    // pseudo-header, then udp header with a zero checksum, then payload
    for (i = ip_src; i < udp_start; i++) begin
        covered.push_back(frame_bytes[i]);
    end
    covered.push_back(8'h00);
    covered.push_back(udp_rx_pkg::IP_PROTO_UDP);
    covered.push_back(udp_len[15:8]);
    covered.push_back(udp_len[7:0]);
    for (i = udp_start; i < frame_bytes.size(); i++) begin
        covered.push_back(frame_bytes[i]);
    end
    csum = internet_checksum(covered);
    if (d.fault == bad_checksum) begin
        csum[15:8] = ~csum[15:8];
    end
    frame_bytes[pay_start - 2] = csum[15:8];
    frame_bytes[pay_start - 1] = csum[7:0];
    if (d.expect_out) begin
        for (i = 0; i < int'(d.pay_len); i++) begin
            beat.data = frame_bytes[pay_start + i];
            beat.sof  = (i == 0);
            beat.eof  = (i == int'(d.pay_len) - 1);
            expect_q.push_back(beat);
        end
    end
    // bytes past the udp length still belong to the frame
    for (i = 0; i < int'(d.junk_trail); i++) begin
        frame_bytes.push_back(8'(take_bits(data_lfsr, 8)));
    end
endfunction

// File: test/udp_rx_tb.sv
`timescale 1ns/100ps

module udp_rx_tb;

    logic                     clock;
    logic                     reset;
    udp_rx_pkg::stream_beat_t in_beat;
    logic                     in_empty;
    logic                     in_rd_en;
    udp_rx_pkg::stream_beat_t out_beat;
    logic                     out_wr_en;
    logic                     out_full;

    udp_rx_pkg::stream_beat_t in_q[$];
    udp_rx_pkg::stream_beat_t got_q[$];
    udp_rx_pkg::stream_beat_t expect_q[$];
    udp_rx_pkg::byte_t        frame_bytes[$];
    logic [15:0]              data_lfsr;
    logic [15:0]              stall_lfsr;
    logic [15:0]              full_lfsr;
    logic                     bp_enable;
    int                       errors;
    int                       checks;
    int                       cycles;

    udp_rx_top u_udp_rx_top (
        .clock     (clock),
        .reset     (reset),
        .in_beat   (in_beat),
        .in_empty  (in_empty),
        .in_rd_en  (in_rd_en),
        .out_beat  (out_beat),
        .out_wr_en (out_wr_en),
        .out_full  (out_full)
    );

    // 16-bit galois lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    // one step per bit taken
    function automatic int unsigned take_bits(inout logic [15:0] s, input int n);
        int unsigned v;
        int          i;
        v = 0;
        for (i = 0; i < n; i++) begin
            v = (v << 1) | int'(s[0]);
            s = lfsr_next(s);
        end
        return v;
    endfunction

    `include "udp_rx_cases.svh"

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // upstream fifo model, pops after a read seen at the falling edge
    initial begin
        logic taken;
        logic stall;
        forever begin
            @(negedge clock);
            taken = in_rd_en && !in_empty;
            @(posedge clock);
            #1;
            if (taken) begin
                void'(in_q.pop_front());
            end
            stall = (take_bits(stall_lfsr, 2) == 3);
            in_empty = (in_q.size() == 0) || stall;
            in_beat  = (in_q.size() == 0) ? '0 : in_q[0];
        end
    end

    // downstream full in stretches of one to four cycles
    initial begin
        int hold;
        hold = 0;
        forever begin
            @(posedge clock);
            #1;
            if (!bp_enable) begin
                out_full = 1'b0;
                hold     = 0;
            end else if (hold == 0) begin
                out_full = 1'(take_bits(full_lfsr, 1));
                hold     = int'(take_bits(full_lfsr, 2));
            end else begin
                hold--;
            end
        end
    end

    always @(negedge clock) begin
        if (!reset && out_wr_en) begin
            if (out_full) begin
                errors++;
                $display("output written while out_full was high at %0t ns", $time);
            end
            got_q.push_back(out_beat);
        end
    end

    task automatic check_beat(input udp_rx_pkg::stream_beat_t got,
                              input udp_rx_pkg::stream_beat_t exp, input int idx);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: beat %0d is %02h sof %b eof %b, expected %02h sof %b eof %b",
                     $time, idx, got.data, got.sof, got.eof, exp.data, exp.sof, exp.eof);
        end
    endtask

    task automatic check_count(input udp_rx_pkg::word_t got, input udp_rx_pkg::word_t exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic run_case(input int idx);
        frame_desc_t              d;
        udp_rx_pkg::stream_beat_t beat;
        int                       i;
        d = CASES[idx];
        @(negedge clock);
        bp_enable = d.backpressure;
        build_frame(d);
        for (i = 0; i < int'(d.junk_lead); i++) begin
            beat = '{data: 8'(take_bits(data_lfsr, 8)), sof: 1'b0, eof: 1'b0};
            in_q.push_back(beat);
        end
        for (i = 0; i < frame_bytes.size(); i++) begin
            beat.data = frame_bytes[i];
            beat.sof  = (i == 0);
            beat.eof  = (i == frame_bytes.size() - 1);
            in_q.push_back(beat);
        end
        if (d.expect_out) begin
            while (got_q.size() == 0 || !got_q[got_q.size() - 1].eof) begin
                @(posedge clock);
            end
        end else begin
            while (in_q.size() != 0) begin
                @(posedge clock);
            end
        end
        check_count(16'(got_q.size()), 16'(expect_q.size()), $sformatf("frame %0d beats", idx));
        for (i = 0; i < got_q.size() && i < expect_q.size(); i++) begin
            check_beat(got_q[i], expect_q[i], i);
        end
        got_q.delete();
    endtask

    initial begin
        int limit;
        cycles = 0;
        limit  = 10 * total_bytes() + 2000;
        while (cycles < limit) begin
            @(posedge clock);
            cycles++;
        end
        $display("timed out after %0d cycles with %0d errors so far", cycles, errors);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        int idx;
        reset      = 1'b1;
        in_beat    = '0;
        in_empty   = 1'b1;
        out_full   = 1'b0;
        bp_enable  = 1'b0;
        errors     = 0;
        checks     = 0;
        data_lfsr  = 16'd55;
        stall_lfsr = 16'd55;
        full_lfsr  = 16'd55;
        repeat (16) @(posedge clock);
        #1;
        reset = 1'b0;
        for (idx = 0; idx < NUM_CASES; idx++) begin
            run_case(idx);
        end
        while (in_q.size() != 0) begin
            @(posedge clock);
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+test
design/udp_rx_pkg.sv
design/payload_fifo.sv
design/udp_checksum.sv
design/frame_parser.sv
design/udp_rx_top.sv
test/udp_rx_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
    --top-module udp_rx_tb -f flist.f -o udp_rx_sim

./obj_dir/udp_rx_sim | tee sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
    exit 1
fi
exit 0
